/* Makefile */
TOP = dma_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

# the log decides pass or fail, the simulator status alone is not enough
sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/dma_arbiter.sv */
module dma_arbiter import dma_pkg::*; (
	input  logic                             clk,
	input  logic                             reset,
	// per-core requests from the checkers
	input  logic [N_CORES-1:0]               dma_val,
	output logic [N_CORES-1:0]               dma_rdy,
	input  logic [N_CORES-1:0][ADDR_W-1:0]   dma_src,
	input  logic [N_CORES-1:0][ADDR_W-1:0]   dma_dest,
	input  dma_op_e [N_CORES-1:0]            dma_op,
	input  logic [N_CORES-1:0][LEN_W-1:0]    dma_len,
	output logic [N_CORES-1:0]               dma_ack,
	// single engine port
	output logic                             eng_val,
	input  logic                             eng_rdy,
	output logic [ADDR_W-1:0]                eng_src,
	output logic [ADDR_W-1:0]                eng_dest,
	output dma_op_e                          eng_op,
	output logic [LEN_W-1:0]                 eng_len,
	input  logic                             eng_done
);

	logic              busy;
	// last winner, search starts just after it
	logic [CORE_W-1:0] ptr;
	logic [CORE_W-1:0] owner;
	logic [CORE_W-1:0] winner;
	logic [CORE_W-1:0] cand;
	logic              found;

	// --------------------------------------------------
	// round-robin pick
	// --------------------------------------------------

	always_comb begin
		found  = 1'b0;
		winner = ptr;
		cand   = ptr;
		// k wraps to zero last, so the previous winner is checked last
		for (int k = 1; k <= N_CORES; k++) begin
			cand = ptr + CORE_W'(k);
			if (!found && dma_val[cand]) begin
				found  = 1'b1;
				winner = cand;
			end
		end
	end

	// no new grant while a transfer is running
	assign eng_val  = !busy && found;
	assign eng_src  = dma_src[winner];
	assign eng_dest = dma_dest[winner];
	assign eng_op   = dma_op[winner];
	assign eng_len  = dma_len[winner];

	// grant and engine accept happen in the same cycle
	assign dma_rdy = (eng_val && eng_rdy) ? (N_CORES'(1) << winner) : '0;
	// steer done back to whoever owns the engine
	assign dma_ack = (busy && eng_done) ? (N_CORES'(1) << owner) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			ptr   <= CORE_W'(N_CORES - 1);
			owner <= '0;
		end else if (eng_val && eng_rdy) begin
			busy  <= 1'b1;
			ptr   <= winner;
			owner <= winner;
		end else if (eng_done) begin
			busy  <= 1'b0;
		end
	end

	// the engine only finishes a transfer that was granted here
	a_done_when_busy: assert property (@(posedge clk) disable iff (reset)
		eng_done |-> busy);

endmodule

/* hw/dma_checker.sv */
module dma_checker import dma_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	// request side, from the split stage
	input  logic                noc_val,
	output logic                noc_rdy,
	input  logic [DOMAIN_W-1:0] noc_domain,
	input  logic [ADDR_W-1:0]   noc_src,
	input  logic [ADDR_W-1:0]   noc_dest,
	input  dma_op_e             noc_op,
	input  logic [LEN_W-1:0]    noc_len,
	input  logic [TAG_W-1:0]    noc_tag,
	// domain level of the controller
	input  logic [DOMAIN_W-1:0] dma_level,
	// towards the arbiter
	output logic                dma_val,
	input  logic                dma_rdy,
	output logic [ADDR_W-1:0]   dma_src,
	output logic [ADDR_W-1:0]   dma_dest,
	output dma_op_e             dma_op,
	output logic [LEN_W-1:0]    dma_len,
	input  logic                dma_ack,
	// acknowledge back to the core
	output logic                ack,
	output dma_status_e         ack_status,
	output logic [DOMAIN_W-1:0] ack_domain,
	output logic [TAG_W-1:0]    ack_tag
);

	chk_state_e          state;
	chk_state_e          state_next;
	logic                accept;
	logic                allowed;

	// latched request
	logic [DOMAIN_W-1:0] domain_q;
	logic [TAG_W-1:0]    tag_q;
	dma_status_e         status_q;

	assign accept  = noc_val && noc_rdy;
	// equal or higher domain may touch memory
	assign allowed = (domain_q >= dma_level);

	// --------------------------------------------------
	// state register and next state
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CHK_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			CHK_IDLE: begin
				if (accept) begin
					state_next = CHK_CHECK;
				end
			end
			// denied requests skip the engine entirely
			CHK_CHECK: state_next = allowed ? CHK_REQ : CHK_RESP;
			// hold until the arbiter grants
			CHK_REQ: begin
				if (dma_rdy) begin
					state_next = CHK_WAIT;
				end
			end
			CHK_WAIT: begin
				if (dma_ack) begin
					state_next = CHK_RESP;
				end
			end
			CHK_RESP: state_next = CHK_IDLE;
			default:  state_next = CHK_IDLE;
		endcase
	end

	// --------------------------------------------------
	// request fields
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (accept) begin
			domain_q <= noc_domain;
			dma_src  <= noc_src;
			dma_dest <= noc_dest;
			dma_op   <= noc_op;
			dma_len  <= noc_len;
			tag_q    <= noc_tag;
		end
		// decision is kept so a later level change cannot flip it
		if (state == CHK_CHECK) begin
			status_q <= allowed ? ST_DONE : ST_DENIED;
		end
	end

	// outputs decoded from the state
	assign noc_rdy    = (state == CHK_IDLE);
	assign dma_val    = (state == CHK_REQ);
	assign ack        = (state == CHK_RESP);
	assign ack_status = status_q;
	assign ack_domain = domain_q;
	assign ack_tag    = tag_q;

	// a grant only reaches a checker that is asking for one
	a_rdy_needs_val: assert property (@(posedge clk) disable iff (reset)
		dma_rdy |-> dma_val);

	// engine done only comes back while this checker waits for it
	a_ack_in_wait: assert property (@(posedge clk) disable iff (reset)
		dma_ack |-> state == CHK_WAIT);

endmodule

/* hw/dma_engine.sv */
module dma_engine import dma_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	// request from the arbiter
	input  logic              eng_val,
	output logic              eng_rdy,
	input  logic [ADDR_W-1:0] eng_src,
	input  logic [ADDR_W-1:0] eng_dest,
	input  dma_op_e           eng_op,
	input  logic [LEN_W-1:0]  eng_len,
	output logic              eng_done,
	// inspection port
	input  logic [ADDR_W-1:0] mem_rd_addr,
	output logic [DATA_W-1:0] mem_rd_data
);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic              busy;
	// words still to move
	logic [LEN_W-1:0]  cnt;
	// pointers wrap modulo the memory size by their width
	logic [ADDR_W-1:0] src_ptr;
	logic [ADDR_W-1:0] dst_ptr;
	dma_op_e           op_q;
	logic [ADDR_W-1:0] fill_val;
	logic              accept;
	logic              step;

	assign eng_rdy  = !busy;
	assign accept   = eng_val && eng_rdy;
	// one word per busy cycle until the count runs out
	assign step     = busy && (cnt != '0);
	// the cycle after the last word, or right after a zero count
	assign eng_done = busy && (cnt == '0);

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt  <= eng_len;
		end else if (step) begin
			cnt  <= cnt - 1'b1;
		end else if (eng_done) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			src_ptr  <= eng_src;
			dst_ptr  <= eng_dest;
			op_q     <= eng_op;
			fill_val <= eng_src;
		end else if (step) begin
			src_ptr  <= src_ptr + 1'b1;
			dst_ptr  <= dst_ptr + 1'b1;
		end
	end

	// --------------------------------------------------
	// memory
	// --------------------------------------------------

	// each word comes out of reset holding its own address
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= DATA_W'(i);
			end
		end else if (step) begin
			// copy reads the current contents, so earlier words of
			// an overlapping copy are seen
			if (op_q == OP_COPY) begin
				mem[dst_ptr] <= mem[src_ptr];
			end else begin
				mem[dst_ptr] <= DATA_W'(fill_val);
			end
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		mem_rd_data <= mem[mem_rd_addr];
	end

endmodule

/* hw/dma_pkg.sv */
package dma_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------

	// cores on the network, one checker each
	localparam int N_CORES   = 4;
	localparam int CORE_W    = 2;
	// higher level means more privileged
	localparam int DOMAIN_W  = 2;
	// word addresses into the internal memory
	localparam int ADDR_W    = 6;
	localparam int DATA_W    = 32;
	// word count, zero moves nothing
	localparam int LEN_W     = 4;
	// opaque tag, echoed back in the ack
	localparam int TAG_W     = 8;
	localparam int MEM_WORDS = 64;

	// --------------------------------------------------
	// encodings
	// --------------------------------------------------

	typedef enum logic {
		OP_COPY = 1'b0,
		OP_FILL = 1'b1
	} dma_op_e;

	typedef enum logic {
		ST_DONE   = 1'b0,
		ST_DENIED = 1'b1
	} dma_status_e;

	typedef enum logic [2:0] {
		CHK_IDLE  = 3'd0,
		CHK_CHECK = 3'd1,
		CHK_REQ   = 3'd2,
		CHK_WAIT  = 3'd3,
		CHK_RESP  = 3'd4
	} chk_state_e;

endpackage

/* hw/dma_req_split.sv */
module dma_req_split import dma_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	// request from the network
	input  logic                req_val,
	output logic                req_rdy,
	input  logic [CORE_W-1:0]   req_core,
	input  logic [DOMAIN_W-1:0] req_domain,
	input  logic [ADDR_W-1:0]   req_src,
	input  logic [ADDR_W-1:0]   req_dest,
	input  dma_op_e             req_op,
	input  logic [LEN_W-1:0]    req_len,
	input  logic [TAG_W-1:0]    req_tag,
	// per-core handshake towards the checkers
	output logic [N_CORES-1:0]  chk_val,
	input  logic [N_CORES-1:0]  chk_rdy,
	// held fields, broadcast to every checker
	output logic [DOMAIN_W-1:0] hold_domain,
	output logic [ADDR_W-1:0]   hold_src,
	output logic [ADDR_W-1:0]   hold_dest,
	output dma_op_e             hold_op,
	output logic [LEN_W-1:0]    hold_len,
	output logic [TAG_W-1:0]    hold_tag
);

	logic              full;
	logic [CORE_W-1:0] hold_core;
	logic              take;
	logic              drain;

	// only take a new request into an empty register
	assign req_rdy = !full;
	assign take    = req_val && req_rdy;
	// register frees once the target checker accepts
	assign drain   = full && chk_rdy[hold_core];

	// offer the held request to its own core only
	assign chk_val = full ? (N_CORES'(1) << hold_core) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (take) begin
			full <= 1'b1;
		end else if (drain) begin
			full <= 1'b0;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (take) begin
			hold_core   <= req_core;
			hold_domain <= req_domain;
			hold_src    <= req_src;
			hold_dest   <= req_dest;
			hold_op     <= req_op;
			hold_len    <= req_len;
			hold_tag    <= req_tag;
		end
	end

	// the network keeps a stalled request in place until it is taken
	a_req_held: assert property (@(posedge clk) disable iff (reset)
		req_val && !req_rdy |=> req_val && $stable(req_core));

endmodule

/* hw/dma_top.sv */
module dma_top import dma_pkg::*; (
	input  logic                             clk,
	input  logic                             reset,
	// network request port
	input  logic                             req_val,
	output logic                             req_rdy,
	input  logic [CORE_W-1:0]                req_core,
	input  logic [DOMAIN_W-1:0]              req_domain,
	input  logic [ADDR_W-1:0]                req_src,
	input  logic [ADDR_W-1:0]                req_dest,
	input  dma_op_e                          req_op,
	input  logic [LEN_W-1:0]                 req_len,
	input  logic [TAG_W-1:0]                 req_tag,
	input  logic [DOMAIN_W-1:0]              dma_level,
	// per-core acknowledges
	output logic [N_CORES-1:0]               ack,
	output dma_status_e [N_CORES-1:0]        ack_status,
	output logic [N_CORES-1:0][DOMAIN_W-1:0] ack_domain,
	output logic [N_CORES-1:0][TAG_W-1:0]    ack_tag,
	// memory inspection
	input  logic [ADDR_W-1:0]                mem_rd_addr,
	output logic [DATA_W-1:0]                mem_rd_data
);

	// split to checkers
	logic [N_CORES-1:0]               chk_val;
	logic [N_CORES-1:0]               chk_rdy;
	logic [DOMAIN_W-1:0]              hold_domain;
	logic [ADDR_W-1:0]                hold_src;
	logic [ADDR_W-1:0]                hold_dest;
	dma_op_e                          hold_op;
	logic [LEN_W-1:0]                 hold_len;
	logic [TAG_W-1:0]                 hold_tag;

	// checkers to arbiter
	logic [N_CORES-1:0]               dma_val;
	logic [N_CORES-1:0]               dma_rdy;
	logic [N_CORES-1:0][ADDR_W-1:0]   dma_src;
	logic [N_CORES-1:0][ADDR_W-1:0]   dma_dest;
	dma_op_e [N_CORES-1:0]            dma_op;
	logic [N_CORES-1:0][LEN_W-1:0]    dma_len;
	logic [N_CORES-1:0]               dma_ack;

	// arbiter to engine
	logic                             eng_val;
	logic                             eng_rdy;
	logic [ADDR_W-1:0]                eng_src;
	logic [ADDR_W-1:0]                eng_dest;
	dma_op_e                          eng_op;
	logic [LEN_W-1:0]                 eng_len;
	logic                             eng_done;

	dma_req_split split_inst (
		.clk(clk), .reset(reset),
		.req_val(req_val), .req_rdy(req_rdy), .req_core(req_core),
		.req_domain(req_domain), .req_src(req_src), .req_dest(req_dest),
		.req_op(req_op), .req_len(req_len), .req_tag(req_tag),
		.chk_val(chk_val), .chk_rdy(chk_rdy),
		.hold_domain(hold_domain), .hold_src(hold_src), .hold_dest(hold_dest),
		.hold_op(hold_op), .hold_len(hold_len), .hold_tag(hold_tag)
	);

	// one checker per core, all compare against the same level
	for (genvar i = 0; i < N_CORES; i++) begin : g_chk
		dma_checker chk_inst (
			.clk(clk), .reset(reset),
			.noc_val(chk_val[i]), .noc_rdy(chk_rdy[i]),
			.noc_domain(hold_domain), .noc_src(hold_src), .noc_dest(hold_dest),
			.noc_op(hold_op), .noc_len(hold_len), .noc_tag(hold_tag),
			.dma_level(dma_level),
			.dma_val(dma_val[i]), .dma_rdy(dma_rdy[i]),
			.dma_src(dma_src[i]), .dma_dest(dma_dest[i]),
			.dma_op(dma_op[i]), .dma_len(dma_len[i]), .dma_ack(dma_ack[i]),
			.ack(ack[i]), .ack_status(ack_status[i]),
			.ack_domain(ack_domain[i]), .ack_tag(ack_tag[i])
		);
	end

	dma_arbiter arb_inst (
		.clk(clk), .reset(reset),
		.dma_val(dma_val), .dma_rdy(dma_rdy), .dma_src(dma_src),
		.dma_dest(dma_dest), .dma_op(dma_op), .dma_len(dma_len),
		.dma_ack(dma_ack),
		.eng_val(eng_val), .eng_rdy(eng_rdy), .eng_src(eng_src),
		.eng_dest(eng_dest), .eng_op(eng_op), .eng_len(eng_len),
		.eng_done(eng_done)
	);

	dma_engine eng_inst (
		.clk(clk), .reset(reset),
		.eng_val(eng_val), .eng_rdy(eng_rdy), .eng_src(eng_src),
		.eng_dest(eng_dest), .eng_op(eng_op), .eng_len(eng_len),
		.eng_done(eng_done),
		.mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
	);

endmodule

/* tb/dma_golden.txt */
// grp level core domain src dest op len tag status chk_addr chk_word (hex, op 0 copy 1 fill)
// grp 00 runs alone, lines sharing a nonzero grp go back to back, grp ff ends the list
00 1 0 2 00 20 0 4 11 0 21 00000001
00 2 1 1 05 08 1 3 22 1 08 00000008
00 2 2 2 2a 30 1 5 33 0 34 0000002a
00 0 3 0 3f 10 1 0 44 0 10 00000010
00 1 1 3 3e 05 0 4 55 0 07 00000000
00 3 0 2 00 00 1 2 f0 1 00 00000000
00 1 2 1 20 3e 0 4 66 0 3f 00000001
00 0 3 1 04 05 0 3 77 0 07 00000004
01 1 2 3 18 10 1 8 a2 0 15 00000018
01 1 0 1 3c 12 1 2 a0 0 13 0000003c
01 1 3 1 2b 13 1 2 a3 0 14 0000002b
01 1 1 2 13 16 0 2 a1 0 16 0000003c
02 2 3 3 10 20 0 5 b3 0 24 0000002b
02 2 1 0 00 00 1 3 b1 1 00 00000002
02 2 0 2 05 22 1 2 b0 0 22 00000005
02 2 2 1 00 00 1 3 b2 1 21 00000018
00 3 1 3 3f 3c 1 f c1 0 0a 0000003f
00 0 2 0 0b 2f 0 1 c2 0 2f 0000000b
ff 0 0 0 00 00 0 0 00 0 00 00000000

/* tb/dma_tb.sv */
module dma_tb
	import dma_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_FIELDS  = 12;
	localparam int MAX_LINES = 32;
	localparam int TIMEOUT   = 500;
	// column positions in a golden line
	localparam int F_GRP     = 0;
	localparam int F_LEVEL   = 1;
	localparam int F_CORE    = 2;
	localparam int F_DOMAIN  = 3;
	localparam int F_SRC     = 4;
	localparam int F_DEST    = 5;
	localparam int F_OP      = 6;
	localparam int F_LEN     = 7;
	localparam int F_TAG     = 8;
	localparam int F_STATUS  = 9;
	localparam int F_ADDR    = 10;
	localparam int F_WORD    = 11;

	logic                             clk;
	logic                             reset;
	logic                             req_val;
	logic                             req_rdy;
	logic [CORE_W-1:0]                req_core;
	logic [DOMAIN_W-1:0]              req_domain;
	logic [ADDR_W-1:0]                req_src;
	logic [ADDR_W-1:0]                req_dest;
	dma_op_e                          req_op;
	logic [LEN_W-1:0]                 req_len;
	logic [TAG_W-1:0]                 req_tag;
	logic [DOMAIN_W-1:0]              dma_level;
	logic [N_CORES-1:0]               ack;
	dma_status_e [N_CORES-1:0]        ack_status;
	logic [N_CORES-1:0][DOMAIN_W-1:0] ack_domain;
	logic [N_CORES-1:0][TAG_W-1:0]    ack_tag;
	logic [ADDR_W-1:0]                mem_rd_addr;
	logic [DATA_W-1:0]                mem_rd_data;

	logic [31:0]         gold [N_FIELDS*MAX_LINES];
	// expected memory, stepped by the engine rules
	logic [DATA_W-1:0]   model [MEM_WORDS];
	// captured acknowledges, one slot per core
	int                  ack_count [N_CORES];
	int                  ack_cyc [N_CORES];
	dma_status_e         ack_st_q [N_CORES];
	logic [DOMAIN_W-1:0] ack_dom_q [N_CORES];
	logic [TAG_W-1:0]    ack_tag_q [N_CORES];
	int                  base_count [N_CORES];
	int                  line_of [N_CORES];
	int                  hs_cyc [MAX_LINES];
	int                  cyc;
	int                  errors;
	int                  tests_passed;
	int                  tests_failed;
	int                  requests_sent;
	int                  rr_ptr;
	bit                  timed_out;
	integer              seed;

	dma_top dma_top_inst (
		.clk(clk), .reset(reset),
		.req_val(req_val), .req_rdy(req_rdy), .req_core(req_core),
		.req_domain(req_domain), .req_src(req_src), .req_dest(req_dest),
		.req_op(req_op), .req_len(req_len), .req_tag(req_tag),
		.dma_level(dma_level),
		.ack(ack), .ack_status(ack_status), .ack_domain(ack_domain), .ack_tag(ack_tag),
		.mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// grab every ack pulse at mid cycle
	always @(negedge clk) begin
		for (int c = 0; c < N_CORES; c++) begin
			if (ack[c]) begin
				ack_count[c] <= ack_count[c] + 1;
				ack_cyc[c]   <= cyc;
				ack_st_q[c]  <= ack_status[c];
				ack_dom_q[c] <= ack_domain[c];
				ack_tag_q[c] <= ack_tag[c];
			end
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic check_equal(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR time %0t: %s expected %0h got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	function automatic bit allowed(input int line);
		return gold[line*N_FIELDS + F_DOMAIN] >= gold[line*N_FIELDS + F_LEVEL];
	endfunction

	// lowest-numbered pending core after the previous winner
	function automatic int next_grant(input int ptr, input logic [N_CORES-1:0] pending);
		int pick;
		int c;
		pick = -1;
		for (int k = N_CORES; k >= 1; k--) begin
			c = (ptr + k) % N_CORES;
			if (pending[c]) begin
				pick = c;
			end
		end
		return pick;
	endfunction

	// one word per step, ascending, pointers wrap at 64
	task automatic apply_model(input int line);
		logic [ADDR_W-1:0] s;
		logic [ADDR_W-1:0] d;
		int                len;
		int                b;
		b   = line * N_FIELDS;
		s   = gold[b + F_SRC][ADDR_W-1:0];
		d   = gold[b + F_DEST][ADDR_W-1:0];
		len = int'(gold[b + F_LEN][LEN_W-1:0]);
		for (int k = 0; k < len; k++) begin
			if (gold[b + F_OP][0] == 1'b0) begin
				model[d] = model[s];
			end else begin
				model[d] = DATA_W'(gold[b + F_SRC][ADDR_W-1:0]);
			end
			s = s + 6'd1;
			d = d + 6'd1;
		end
	endtask

	// caller sits just after a rising edge, returns on the handshake edge
	task automatic send_req(input int line, output int hs);
		int b;
		int t;
		b = line * N_FIELDS;
		hs = -1;
		req_val    <= 1'b1;
		req_core   <= gold[b + F_CORE][CORE_W-1:0];
		req_domain <= gold[b + F_DOMAIN][DOMAIN_W-1:0];
		req_src    <= gold[b + F_SRC][ADDR_W-1:0];
		req_dest   <= gold[b + F_DEST][ADDR_W-1:0];
		req_op     <= dma_op_e'(gold[b + F_OP][0]);
		req_len    <= gold[b + F_LEN][LEN_W-1:0];
		req_tag    <= gold[b + F_TAG][TAG_W-1:0];
		t = 0;
		@(negedge clk);
		while (!req_rdy && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!req_rdy) begin
			$display("timeout: request of golden line %0d was never accepted", line);
			timed_out = 1'b1;
			return;
		end
		@(posedge clk);
		hs = cyc;
		requests_sent++;
	endtask

	function automatic bit acks_arrived(input logic [N_CORES-1:0] cores);
		bit all_in;
		all_in = 1'b1;
		for (int c = 0; c < N_CORES; c++) begin
			if (cores[c] && ack_count[c] == base_count[c]) begin
				all_in = 1'b0;
			end
		end
		return all_in;
	endfunction

	task automatic wait_acks(input logic [N_CORES-1:0] cores);
		int t;
		t = 0;
		while (!acks_arrived(cores) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!acks_arrived(cores)) begin
			$display("timeout: no acknowledge came back for cores %b", cores);
			timed_out = 1'b1;
		end
	endtask

	// registered read port, data one cycle after the address
	task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		@(posedge clk);
		mem_rd_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = mem_rd_data;
	endtask

	// --------------------------------------------------
	// one test, a single request or a burst
	// --------------------------------------------------

	task automatic run_group(input int first, input int n);
		logic [N_CORES-1:0] cores;
		logic [N_CORES-1:0] pending;
		logic [DATA_W-1:0]  data;
		int                 b;
		int                 c;
		int                 g;
		int                 hs;
		int                 gap;
		int                 first_ok;
		int                 errs_before;
		errs_before = errors;
		cores = '0;
		gap = {$random(seed)} % 4;
		@(posedge clk);
		repeat (gap) @(posedge clk);
		dma_level <= gold[first*N_FIELDS + F_LEVEL][DOMAIN_W-1:0];
		for (int i = 0; i < n; i++) begin
			c = int'(gold[(first + i)*N_FIELDS + F_CORE][CORE_W-1:0]);
			cores[c] = 1'b1;
			base_count[c] = ack_count[c];
			send_req(first + i, hs);
			hs_cyc[first + i] = hs;
			if (timed_out) begin
				return;
			end
		end
		req_val <= 1'b0;
		wait_acks(cores);
		if (timed_out) begin
			return;
		end
		for (int i = 0; i < n; i++) begin
			b = (first + i) * N_FIELDS;
			c = int'(gold[b + F_CORE][CORE_W-1:0]);
			check_equal($sformatf("ack_status[%0d]", c), gold[b + F_STATUS], 32'(ack_st_q[c]));
			check_equal($sformatf("ack_domain[%0d]", c), gold[b + F_DOMAIN], 32'(ack_dom_q[c]));
			check_equal($sformatf("ack_tag[%0d]", c), gold[b + F_TAG], 32'(ack_tag_q[c]));
			// one cycle in the split, then CHECK and RESP
			if (!allowed(first + i)) begin
				check_equal($sformatf("ack[%0d] latency", c), 32'd3,
					32'(ack_cyc[c] - hs_cyc[first + i]));
			end
		end
		pending = '0;
		first_ok = -1;
		for (int i = 0; i < n; i++) begin
			if (allowed(first + i)) begin
				c = int'(gold[(first + i)*N_FIELDS + F_CORE][CORE_W-1:0]);
				line_of[c] = first + i;
				pending[c] = 1'b1;
				if (first_ok < 0) begin
					first_ok = c;
				end
			end
		end
		// engine is idle when a group starts, the first allowed request wins at once
		if (first_ok >= 0) begin
			apply_model(line_of[first_ok]);
			rr_ptr = first_ok;
			pending[first_ok] = 1'b0;
		end
		while (pending != '0) begin
			g = next_grant(rr_ptr, pending);
			apply_model(line_of[g]);
			rr_ptr = g;
			pending[g] = 1'b0;
		end
		for (int i = 0; i < n; i++) begin
			b = (first + i) * N_FIELDS;
			c = int'(gold[b + F_CORE][CORE_W-1:0]);
			read_word(gold[b + F_ADDR][ADDR_W-1:0], data);
			check_equal("mem_rd_data", gold[b + F_WORD], data);
			check_equal("mem_rd_data vs model", model[gold[b + F_ADDR][ADDR_W-1:0]], data);
			check_equal($sformatf("ack[%0d] count", c), 32'(base_count[c] + 1),
				32'(ack_count[c]));
		end
		if (errors == errs_before) begin
			tests_passed++;
			$display("test at line %0d: %0d request(s) passed", first, n);
		end else begin
			tests_failed++;
			$display("test at line %0d: %0d request(s) failed", first, n);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		int               line;
		int               n;
		int               total;
		int               errs_before;
		logic [DATA_W-1:0] data;
		clk = 1'b0;
		reset = 1'b1;
		req_val = 1'b0;
		req_core = '0;
		req_domain = '0;
		req_src = '0;
		req_dest = '0;
		req_op = OP_COPY;
		req_len = '0;
		req_tag = '0;
		dma_level = '0;
		mem_rd_addr = '0;
		cyc = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		requests_sent = 0;
		timed_out = 1'b0;
		seed = 32'h91698761;
		// no winner yet, core 0 has the first turn
		rr_ptr = N_CORES - 1;
		for (int i = 0; i < N_CORES; i++) begin
			ack_count[i] = 0;
			ack_cyc[i] = 0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			model[i] = DATA_W'(i);
		end
		for (int i = 0; i < N_FIELDS*MAX_LINES; i++) begin
			gold[i] = 32'hffffffff;
		end
		$readmemh("tb/dma_golden.txt", gold);
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		line = 0;
		while (line < MAX_LINES && gold[line*N_FIELDS + F_GRP] != 32'hff && !timed_out) begin
			n = 1;
			if (gold[line*N_FIELDS + F_GRP] != 32'h0) begin
				while (line + n < MAX_LINES &&
						gold[(line + n)*N_FIELDS + F_GRP] == gold[line*N_FIELDS + F_GRP]) begin
					n++;
				end
			end
			run_group(line, n);
			if (timed_out) begin
				tests_failed++;
				$display("test at line %0d: stopped on a timeout", line);
			end
			line = line + n;
		end
		// whole memory against the model, plus no stray acks
		if (!timed_out) begin
			errs_before = errors;
			for (int a = 0; a < MEM_WORDS; a++) begin
				read_word(ADDR_W'(a), data);
				check_equal($sformatf("mem_rd_data @%0h", a), model[a], data);
			end
			total = 0;
			for (int c = 0; c < N_CORES; c++) begin
				total = total + ack_count[c];
			end
			check_equal("ack total", 32'(requests_sent), 32'(total));
			if (errors == errs_before) begin
				tests_passed++;
				$display("test memory sweep: passed");
			end else begin
				tests_failed++;
				$display("test memory sweep: failed");
			end
		end
		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* vlog.f */
hw/dma_pkg.sv
hw/dma_req_split.sv
hw/dma_checker.sv
hw/dma_arbiter.sv
hw/dma_engine.sv
hw/dma_top.sv
tb/dma_tb.sv
